//--- common/decode_pkg.sv
`default_nettype none

package decode_pkg;

    typedef enum logic [2:0] {
        unit_alu       = 3'd0,
        unit_branch    = 3'd1,
        unit_jump_link = 3'd2,  // Branch that also writes the link address
        unit_mul       = 3'd3,
        unit_div       = 3'd4,
        unit_mem       = 3'd5,
        unit_except    = 3'd6,
        unit_nop       = 3'd7
    } unit_e;

    typedef enum logic [3:0] {
        op_and    = 4'd0,
        op_or     = 4'd1,
        op_nor    = 4'd2,
        op_xor    = 4'd3,
        op_add    = 4'd4,
        op_sub    = 4'd5,
        op_sll    = 4'd6,
        op_srl    = 4'd7,
        op_sra    = 4'd8,
        op_slt    = 4'd9,
        op_sltu   = 4'd10,
        op_pass_b = 4'd12   // Second operand straight through
    } alu_op_e;

    typedef enum logic {
        src1_reg = 1'b0,
        src1_pc  = 1'b1
    } src1_e;

    typedef enum logic [1:0] {
        src2_reg  = 2'd0,
        src2_imm  = 2'd1,
        src2_cmp  = 2'd2,   // rd as compare operand
        src2_four = 2'd3
    } src2_e;

    // Return-stack classes seen by the predictor
    typedef enum logic [2:0] {
        jk_not_jump = 3'd0,
        jk_direct   = 3'd1,
        jk_ret      = 3'd4,
        jk_indirect = 3'd5,
        jk_call     = 3'd6,
        jk_jump     = 3'd7
    } jump_kind_e;

    typedef enum logic [5:0] {
        excp_none = 6'h00,
        excp_adef = 6'h08,
        excp_sys  = 6'h0B,
        excp_brk  = 6'h0C,
        excp_ine  = 6'h0D
    } excp_code_e;

    // ir[31:15] of the two trap instructions
    localparam logic [16:0] break_enc   = 17'h00054;
    localparam logic [16:0] syscall_enc = 17'h00056;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] ir;
        logic        fetch_excp;
        logic [14:0] fetch_excp_code;
    } fetch_t;

    typedef struct packed {
        logic        hit;
        unit_e       unit;
        logic [3:0]  subop;     // Size, mul/div variant or branch condition
        alu_op_e     alu_op;
        src1_e       src1;
        src2_e       src2;
        jump_kind_e  kind;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic        regwrite;
        logic        memread;
        logic        memwrite;
        logic        use_rd;
    } class_dec_t;

    typedef struct packed {
        unit_e       unit;
        logic [3:0]  subop;
        alu_op_e     alu_op;
        src1_e       src1;
        src2_e       src2;
        jump_kind_e  kind;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic        regwrite;
        logic        memread;
        logic        memwrite;
        logic        use_rd;
        logic [31:0] pc;
        excp_code_e  excp;
        logic [14:0] excp_info;
    } decoded_t;

endpackage

`default_nettype wire

//--- source/pipe_reg.sv
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    assign in_ready  = !full || out_ready;  // Empty, or draining this cycle
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk)
    begin
        if (rst)
            full <= 1'b0;
        else if (in_ready)
            full <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
            data_q <= in_data;
    end

endmodule

`default_nettype wire

//--- decoder/alu_decoder.sv
`default_nettype none

module alu_decoder (
    input  logic [31:0]            ir,
    output decode_pkg::class_dec_t res
);
    import decode_pkg::*;

    logic use_rk;
    logic use_rj;

    always_comb
    begin
        res    = '0;    // Unit alu, both sources from registers
        use_rk = 1'b0;
        use_rj = 1'b1;
        case (ir[31:26])
            6'b000000:
                case (ir[25:22])
                    4'b0000:
                    begin
                        res.hit = 1'b1;
                        use_rk  = 1'b1;
                        case (ir[21:15])
                            7'b0100000: res.alu_op = op_add;
                            7'b0100010: res.alu_op = op_sub;
                            7'b0100100: res.alu_op = op_slt;
                            7'b0100101: res.alu_op = op_sltu;
                            7'b0101000: res.alu_op = op_nor;
                            7'b0101001: res.alu_op = op_and;
                            7'b0101010: res.alu_op = op_or;
                            7'b0101011: res.alu_op = op_xor;
                            7'b0101110: res.alu_op = op_sll;
                            7'b0101111: res.alu_op = op_srl;
                            7'b0110000: res.alu_op = op_sra;
                            7'b0111000, 7'b0111001, 7'b0111010:
                            begin
                                res.unit  = unit_mul;   // MUL.W, MULH.W, MULH.WU
                                res.subop = {2'b00, ir[16:15]};
                            end
                            7'b1000000, 7'b1000001, 7'b1000010, 7'b1000011:
                            begin
                                res.unit  = unit_div;   // DIV.W, MOD.W, DIV.WU, MOD.WU
                                res.subop = {2'b00, ir[16:15]};
                            end
                            default: res.hit = 1'b0;
                        endcase
                    end
                    4'b0001:
                        if (ir[21:20] == 2'b00 && ir[17:15] == 3'b001 && ir[19:18] != 2'b11)
                        begin
                            res.hit  = 1'b1;
                            res.src2 = src2_imm;
                            res.imm  = {27'd0, ir[14:10]};  // Shift amount
                            case (ir[19:18])
                                2'b00:   res.alu_op = op_sll;
                                2'b01:   res.alu_op = op_srl;
                                default: res.alu_op = op_sra;
                            endcase
                        end
                    4'b1000, 4'b1001, 4'b1010:
                    begin
                        res.hit  = 1'b1;
                        res.src2 = src2_imm;
                        res.imm  = {{20{ir[21]}}, ir[21:10]};
                        case (ir[23:22])
                            2'b00:   res.alu_op = op_slt;
                            2'b01:   res.alu_op = op_sltu;
                            default: res.alu_op = op_add;
                        endcase
                    end
                    4'b1101, 4'b1110, 4'b1111:
                    begin
                        res.hit  = 1'b1;
                        res.src2 = src2_imm;
                        res.imm  = {20'd0, ir[21:10]};  // Logic ops zero extend
                        case (ir[23:22])
                            2'b01:   res.alu_op = op_and;
                            2'b10:   res.alu_op = op_or;
                            default: res.alu_op = op_xor;
                        endcase
                    end
                    default: res.hit = 1'b0;
                endcase
            6'b000101, 6'b000111:
                if (!ir[25])
                begin
                    res.hit  = 1'b1;
                    use_rj   = 1'b0;
                    res.src2 = src2_imm;
                    res.imm  = {ir[24:5], 12'd0};
                    if (ir[27])
                    begin
                        res.alu_op = op_add;    // PCADDU12I
                        res.src1   = src1_pc;
                    end
                    else
                        res.alu_op = op_pass_b; // LU12I.W
                end
            default: res.hit = 1'b0;
        endcase

        if (res.hit)
        begin
            res.rd       = ir[4:0];
            res.regwrite = 1'b1;
            if (use_rj)
                res.rj = ir[9:5];
            if (use_rk)
                res.rk = ir[14:10];
        end
    end

endmodule

`default_nettype wire

//--- decoder/mem_decoder.sv
`default_nettype none

module mem_decoder (
    input  logic [31:0]            ir,
    output decode_pkg::class_dec_t res
);
    import decode_pkg::*;

    logic       mem_major;
    logic       acc_hit;
    logic [3:0] size_op;
    logic       is_store;
    logic       is_preld;
    logic       is_dbar;

    assign mem_major = ir[31:26] == 6'b001010;
    assign is_preld  = mem_major && ir[25:22] == 4'b1011;
    assign is_dbar   = ir[31:15] == 17'b0011_1000_0111_0010_0;
    assign is_store  = size_op >= 4'd3 && size_op <= 4'd5;

    always_comb
    begin
        acc_hit = 1'b1;
        size_op = 4'd0;
        case (ir[25:22])
            4'b0000: size_op = 4'd0;    // LD.B
            4'b0001: size_op = 4'd1;    // LD.H
            4'b0010: size_op = 4'd2;    // LD.W
            4'b0100: size_op = 4'd3;    // ST.B
            4'b0101: size_op = 4'd4;    // ST.H
            4'b0110: size_op = 4'd5;    // ST.W
            4'b1000: size_op = 4'd6;    // LD.BU
            4'b1001: size_op = 4'd7;    // LD.HU
            default: acc_hit = 1'b0;
        endcase
    end

    always_comb
    begin
        res = '0;
        if (mem_major && acc_hit)
        begin
            res.hit      = 1'b1;
            res.unit     = unit_mem;
            res.subop    = size_op;
            res.src2     = src2_imm;
            res.imm      = {{20{ir[21]}}, ir[21:10]};
            res.rj       = ir[9:5];
            res.rd       = ir[4:0];
            res.memread  = !is_store;
            res.regwrite = !is_store;
            res.memwrite = is_store;
            res.use_rd   = is_store;    // Store data sits in rd
        end
        else if (is_preld || is_dbar)
        begin
            res.hit  = 1'b1;
            res.unit = unit_nop;
        end
    end

endmodule

`default_nettype wire

//--- decoder/branch_decoder.sv
`default_nettype none

module branch_decoder (
    input  logic [31:0]            ir,
    output decode_pkg::class_dec_t res
);
    import decode_pkg::*;

    logic [31:0] offs16;
    logic [31:0] offs26;

    assign offs16 = {{14{ir[25]}}, ir[25:10], 2'b00};
    assign offs26 = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00};

    always_comb
    begin
        res = '0;
        case (ir[31:26])
            6'b010011:  // JIRL
            begin
                res.hit      = 1'b1;
                res.unit     = unit_jump_link;
                res.alu_op   = op_add;
                res.src1     = src1_pc;
                res.src2     = src2_four;
                res.rj       = ir[9:5];
                res.rd       = ir[4:0];
                res.imm      = offs16;
                res.regwrite = 1'b1;
                if (ir[4:0] == 5'd0 && ir[9:5] == 5'd1 && ir[25:10] == 16'd0)
                    res.kind = jk_ret;
                else if (ir[4:0] == 5'd1)
                    res.kind = jk_call;
                else
                    res.kind = jk_indirect;
            end
            6'b010100:  // B
            begin
                res.hit  = 1'b1;
                res.unit = unit_branch;
                res.imm  = offs26;
                res.kind = jk_jump;
            end
            6'b010101:  // BL
            begin
                res.hit      = 1'b1;
                res.unit     = unit_jump_link;
                res.subop    = 4'd1;
                res.alu_op   = op_add;
                res.src1     = src1_pc;
                res.src2     = src2_four;
                res.rd       = 5'd1;
                res.imm      = offs26;
                res.regwrite = 1'b1;
                res.kind     = jk_call;
            end
            6'b010110, 6'b010111, 6'b011000, 6'b011001, 6'b011010, 6'b011011:
            begin
                res.hit    = 1'b1;
                res.unit   = unit_branch;
                res.subop  = ir[29:26] - 4'd5;  // BEQ 1 through BGEU 6
                res.src2   = src2_cmp;
                res.rj     = ir[9:5];
                res.rd     = ir[4:0];
                res.imm    = offs16;
                res.use_rd = 1'b1;
                res.kind   = jk_direct;
                case (ir[28:27])
                    2'b11:   res.alu_op = op_sub;   // BEQ, BNE
                    2'b00:   res.alu_op = op_slt;   // BLT, BGE
                    default: res.alu_op = op_sltu;
                endcase
            end
            default: res.hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- decoder/decode_select.sv
`default_nettype none

module decode_select (
    input  logic [31:0]            pc,
    input  logic [31:0]            ir,
    input  logic                   fetch_excp,
    input  logic [14:0]            fetch_excp_code,
    input  decode_pkg::class_dec_t alu_res,
    input  decode_pkg::class_dec_t mem_res,
    input  decode_pkg::class_dec_t br_res,
    output decode_pkg::decoded_t   dec
);
    import decode_pkg::*;

    class_dec_t hit_res;

    // Opcode sets are disjoint, so at most one of these hits
    always_comb
    begin
        if (alu_res.hit)
            hit_res = alu_res;
        else if (mem_res.hit)
            hit_res = mem_res;
        else
            hit_res = br_res;
    end

    always_comb
    begin
        dec    = '0;
        dec.pc = pc;
        if (fetch_excp)
        begin
            dec.unit      = unit_except;
            dec.excp_info = fetch_excp_code;
        end
        else if (pc[1:0] != 2'b00)
        begin
            dec.unit = unit_except;
            dec.excp = excp_adef;
        end
        else if (ir[31:15] == syscall_enc || ir[31:15] == break_enc)
        begin
            dec.unit = unit_except;
            dec.excp = (ir[31:15] == syscall_enc) ? excp_sys : excp_brk;
        end
        else if (hit_res.hit)
        begin
            dec.unit     = hit_res.unit;
            dec.subop    = hit_res.subop;
            dec.alu_op   = hit_res.alu_op;
            dec.src1     = hit_res.src1;
            dec.src2     = hit_res.src2;
            dec.kind     = hit_res.kind;
            dec.rk       = hit_res.rk;
            dec.rj       = hit_res.rj;
            dec.rd       = hit_res.rd;
            dec.imm      = hit_res.imm;
            dec.regwrite = hit_res.regwrite;
            dec.memread  = hit_res.memread;
            dec.memwrite = hit_res.memwrite;
            dec.use_rd   = hit_res.use_rd;
        end
        else
        begin
            dec.unit = unit_except;  // Reserved or dropped encoding
            dec.excp = excp_ine;
        end
    end

endmodule

`default_nettype wire

//--- source/decode_top.sv
`default_nettype none

module decode_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  decode_pkg::fetch_t   in_pkt,
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::decoded_t out_dec
);
    import decode_pkg::*;

    logic       f_valid;
    logic       f_ready;
    fetch_t     f_pkt;
    class_dec_t alu_res;
    class_dec_t mem_res;
    class_dec_t br_res;
    decoded_t   dec;

    pipe_reg #(.payload_t(fetch_t)) u_fetch_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_pkt),
        .out_valid (f_valid),
        .out_ready (f_ready),
        .out_data  (f_pkt)
    );

    alu_decoder u_alu_dec (.ir(f_pkt.ir), .res(alu_res));

    mem_decoder u_mem_dec (.ir(f_pkt.ir), .res(mem_res));

    branch_decoder u_br_dec (.ir(f_pkt.ir), .res(br_res));

    decode_select u_sel (
        .pc              (f_pkt.pc),
        .ir              (f_pkt.ir),
        .fetch_excp      (f_pkt.fetch_excp),
        .fetch_excp_code (f_pkt.fetch_excp_code),
        .alu_res         (alu_res),
        .mem_res         (mem_res),
        .br_res          (br_res),
        .dec             (dec)
    );

    pipe_reg #(.payload_t(decoded_t)) u_dec_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (f_valid),
        .in_ready  (f_ready),
        .in_data   (dec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_dec)
    );

endmodule

`default_nettype wire

//--- tests/decode_props.sv
`default_nettype none

module decode_props (
    input logic                 clk,
    input logic                 rst,
    input logic                 in_valid,
    input logic                 in_ready,
    input decode_pkg::fetch_t   in_pkt,
    input logic                 out_valid,
    input logic                 out_ready,
    input decode_pkg::decoded_t out_dec
);
    timeunit 1ns;
    timeprecision 1ps;

    a_reset_idle: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high after a reset cycle");

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_dec)))
        else $error("Stalled output changed before it was taken");

    a_in_hold: assert property (@(posedge clk) disable iff (rst)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_pkt)))
        else $error("Stalled input changed before it was taken");

endmodule

bind decode_top decode_props props0 (.*);

`default_nettype wire

//--- tests/decode_tb.sv
`default_nettype none

module decode_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import decode_pkg::*;

    localparam int n_items   = 400;
    localparam int max_cycle = 4 * n_items + 100;

    // One instruction form: fixed opcode bits plus expected decode attributes
    typedef struct packed {
        logic [31:0] match;
        logic [31:0] mask;
        unit_e       unit;
        logic [3:0]  subop;
        alu_op_e     op;
        src1_e       s1;
        src2_e       s2;
        jump_kind_e  kind;
        logic [2:0]  immk;      // Immediate format
        logic [3:0]  regs;      // rj, rk, rd, fixed rd 1
        logic [3:0]  flags;     // regwrite, memread, memwrite, use_rd
        excp_code_e  ex;
    } tmpl_t;

    logic     clk;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    fetch_t   in_pkt;
    logic     out_valid;
    logic     out_ready;
    decoded_t out_dec;

    logic [15:0] lfsr = 16'd2598;
    tmpl_t       tmpl[$];
    decoded_t    exp_q[$];
    int          sent;
    int          recv;
    int          cycles;

    decode_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_dec   (out_dec)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16+x^14+x^13+x^11+1
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic add_t(input logic [31:0] match, input logic [31:0] mask, input unit_e unit,
                         input logic [3:0] subop, input alu_op_e op, input src1_e s1,
                         input src2_e s2, input jump_kind_e kind, input logic [2:0] immk,
                         input logic [3:0] regs, input logic [3:0] flags, input excp_code_e ex);
        tmpl_t t;
        t = {match, mask, unit, subop, op, s1, s2, kind, immk, regs, flags, ex};
        tmpl.push_back(t);
    endtask

    task automatic add_rrr(input logic [16:0] opc, input alu_op_e op, input unit_e unit,
                           input logic [3:0] subop);
        add_t({opc, 15'd0}, 32'hFFFF8000, unit, subop, op, src1_reg, src2_reg, jk_not_jump,
              3'd0, 4'b1110, 4'b1000, excp_none);
    endtask

    task automatic add_imm(input logic [31:0] match, input logic [31:0] mask, input alu_op_e op,
                           input src1_e s1, input logic [2:0] immk, input logic [3:0] regs);
        add_t(match, mask, unit_alu, 4'd0, op, s1, src2_imm, jk_not_jump, immk, regs,
              4'b1000, excp_none);
    endtask

    task automatic add_mem(input logic [9:0] opc, input logic [3:0] size, input logic store);
        add_t({opc, 22'd0}, 32'hFFC00000, unit_mem, size, op_and, src1_reg, src2_imm,
              jk_not_jump, 3'd2, 4'b1010, store ? 4'b0011 : 4'b1100, excp_none);
    endtask

    task automatic add_cond(input logic [31:0] match, input logic [3:0] subop, input alu_op_e op);
        add_t(match, 32'hFC000000, unit_branch, subop, op, src1_reg, src2_cmp, jk_direct,
              3'd5, 4'b1010, 4'b0001, excp_none);
    endtask

    task automatic add_exc(input logic [31:0] match, input logic [31:0] mask,
                           input excp_code_e ex);
        add_t(match, mask, unit_except, 4'd0, op_and, src1_reg, src2_reg, jk_not_jump,
              3'd0, 4'b0000, 4'b0000, ex);
    endtask

    task automatic build_table();
        add_rrr(17'h20, op_add, unit_alu, 4'd0);
        add_rrr(17'h22, op_sub, unit_alu, 4'd0);
        add_rrr(17'h24, op_slt, unit_alu, 4'd0);
        add_rrr(17'h25, op_sltu, unit_alu, 4'd0);
        add_rrr(17'h28, op_nor, unit_alu, 4'd0);
        add_rrr(17'h29, op_and, unit_alu, 4'd0);
        add_rrr(17'h2A, op_or, unit_alu, 4'd0);
        add_rrr(17'h2B, op_xor, unit_alu, 4'd0);
        add_rrr(17'h2E, op_sll, unit_alu, 4'd0);
        add_rrr(17'h2F, op_srl, unit_alu, 4'd0);
        add_rrr(17'h30, op_sra, unit_alu, 4'd0);
        add_rrr(17'h38, op_and, unit_mul, 4'd0);    // MUL.W
        add_rrr(17'h39, op_and, unit_mul, 4'd1);
        add_rrr(17'h3A, op_and, unit_mul, 4'd2);
        add_rrr(17'h40, op_and, unit_div, 4'd0);    // DIV.W
        add_rrr(17'h41, op_and, unit_div, 4'd1);
        add_rrr(17'h42, op_and, unit_div, 4'd2);
        add_rrr(17'h43, op_and, unit_div, 4'd3);
        add_imm(32'h00408000, 32'hFFFF8000, op_sll, src1_reg, 3'd1, 4'b1010);
        add_imm(32'h00448000, 32'hFFFF8000, op_srl, src1_reg, 3'd1, 4'b1010);
        add_imm(32'h00488000, 32'hFFFF8000, op_sra, src1_reg, 3'd1, 4'b1010);
        add_imm(32'h02000000, 32'hFFC00000, op_slt, src1_reg, 3'd2, 4'b1010);
        add_imm(32'h02400000, 32'hFFC00000, op_sltu, src1_reg, 3'd2, 4'b1010);
        add_imm(32'h02800000, 32'hFFC00000, op_add, src1_reg, 3'd2, 4'b1010);
        add_imm(32'h03400000, 32'hFFC00000, op_and, src1_reg, 3'd3, 4'b1010);
        add_imm(32'h03800000, 32'hFFC00000, op_or, src1_reg, 3'd3, 4'b1010);
        add_imm(32'h03C00000, 32'hFFC00000, op_xor, src1_reg, 3'd3, 4'b1010);
        add_imm(32'h14000000, 32'hFE000000, op_pass_b, src1_reg, 3'd4, 4'b0010);
        add_imm(32'h1C000000, 32'hFE000000, op_add, src1_pc, 3'd4, 4'b0010);
        add_mem(10'h0A0, 4'd0, 1'b0);
        add_mem(10'h0A1, 4'd1, 1'b0);
        add_mem(10'h0A2, 4'd2, 1'b0);
        add_mem(10'h0A4, 4'd3, 1'b1);
        add_mem(10'h0A5, 4'd4, 1'b1);
        add_mem(10'h0A6, 4'd5, 1'b1);
        add_mem(10'h0A8, 4'd6, 1'b0);
        add_mem(10'h0A9, 4'd7, 1'b0);
        add_t(32'h2AC00000, 32'hFFC00000, unit_nop, 4'd0, op_and, src1_reg, src2_reg,
              jk_not_jump, 3'd0, 4'b0000, 4'b0000, excp_none);     // PRELD
        add_t(32'h38720000, 32'hFFFF8000, unit_nop, 4'd0, op_and, src1_reg, src2_reg,
              jk_not_jump, 3'd0, 4'b0000, 4'b0000, excp_none);     // DBAR
        add_t(32'h4C000020, 32'hFFFFFFFF, unit_jump_link, 4'd0, op_add, src1_pc, src2_four,
              jk_ret, 3'd5, 4'b1010, 4'b1000, excp_none);          // JIRL return form
        add_t(32'h4C000001, 32'hFC00001F, unit_jump_link, 4'd0, op_add, src1_pc, src2_four,
              jk_call, 3'd5, 4'b1010, 4'b1000, excp_none);
        add_t(32'h4C000000, 32'hFC000000, unit_jump_link, 4'd0, op_add, src1_pc, src2_four,
              jk_indirect, 3'd5, 4'b1010, 4'b1000, excp_none);
        add_t(32'h50000000, 32'hFC000000, unit_branch, 4'd0, op_and, src1_reg, src2_reg,
              jk_jump, 3'd6, 4'b0000, 4'b0000, excp_none);         // B
        add_t(32'h54000000, 32'hFC000000, unit_jump_link, 4'd1, op_add, src1_pc, src2_four,
              jk_call, 3'd6, 4'b0001, 4'b1000, excp_none);         // BL
        add_cond(32'h58000000, 4'd1, op_sub);
        add_cond(32'h5C000000, 4'd2, op_sub);
        add_cond(32'h60000000, 4'd3, op_slt);
        add_cond(32'h64000000, 4'd4, op_slt);
        add_cond(32'h68000000, 4'd5, op_sltu);
        add_cond(32'h6C000000, 4'd6, op_sltu);
        add_exc(32'h002B0000, 32'hFFFF8000, excp_sys);
        add_exc(32'h002A0000, 32'hFFFF8000, excp_brk);
        add_exc(32'h04000000, 32'hFC000000, excp_ine);  // CSR, CACOP, ERTN space
        add_exc(32'h06483800, 32'hFFFFFFFF, excp_ine);
        add_exc(32'h20000000, 32'hFF000000, excp_ine);  // LL.W
        add_exc(32'h21000000, 32'hFF000000, excp_ine);  // SC.W
        add_exc(32'h38728000, 32'hFFFF8000, excp_ine);  // IBAR
        add_exc(32'h00006000, 32'hFFFFFC00, excp_ine);  // RDTIMEL.W
        add_exc(32'h003F8000, 32'hFFFF8000, excp_ine);
        add_exc(32'h004C8000, 32'hFFFF8000, excp_ine);
        add_exc(32'h70000000, 32'hFC000000, excp_ine);
    endtask

    function automatic int find_tmpl(input logic [31:0] ir);
        for (int i = 0; i < tmpl.size(); i++)
            if ((ir & tmpl[i].mask) == tmpl[i].match)
                return i;
        return -1;
    endfunction

    function automatic decoded_t decode_ref(input fetch_t p);
        decoded_t    d;
        tmpl_t       t;
        int          idx;
        logic [31:0] ir;
        ir   = p.ir;
        d    = '0;
        d.pc = p.pc;
        idx  = find_tmpl(ir);
        if (p.fetch_excp)
        begin
            d.unit      = unit_except;
            d.excp_info = p.fetch_excp_code;
            return d;
        end
        if (p.pc[1:0] != 2'b00)
        begin
            d.unit = unit_except;
            d.excp = excp_adef;
            return d;
        end
        if (idx < 0)
        begin
            d.unit = unit_except;
            d.excp = excp_ine;
            return d;
        end
        t = tmpl[idx];
        d.unit = t.unit;
        d.excp = t.ex;
        if (t.ex != excp_none)
            return d;
        d.subop  = t.subop;
        d.alu_op = t.op;
        d.src1   = t.s1;
        d.src2   = t.s2;
        d.kind   = t.kind;
        d.rj     = t.regs[3] ? ir[9:5] : 5'd0;
        d.rk     = t.regs[2] ? ir[14:10] : 5'd0;
        d.rd     = t.regs[0] ? 5'd1 : (t.regs[1] ? ir[4:0] : 5'd0);
        {d.regwrite, d.memread, d.memwrite, d.use_rd} = t.flags;
        case (t.immk)
            3'd1: d.imm = {27'd0, ir[14:10]};
            3'd2: d.imm = {{20{ir[21]}}, ir[21:10]};
            3'd3: d.imm = {20'd0, ir[21:10]};
            3'd4: d.imm = {ir[24:5], 12'd0};
            3'd5: d.imm = {{14{ir[25]}}, ir[25:10], 2'b00};
            3'd6: d.imm = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00};
            default: d.imm = '0;
        endcase
        return d;
    endfunction

    function automatic fetch_t make_pkt();
        fetch_t      p;
        tmpl_t       t;
        logic [31:0] r;
        int          idx;
        r    = take_bits(6);
        idx  = int'(r) % tmpl.size();
        t    = tmpl[idx];
        p.ir = t.match | (take_bits(32) & ~t.mask);
        r    = take_bits(30);
        p.pc = {r[29:0], 2'b00};
        r    = take_bits(4);
        if (r == 0)
        begin
            r          = take_bits(2);
            p.pc[1:0] = r[1:0];
        end
        r                 = take_bits(5);
        p.fetch_excp      = (r == 0);
        r                 = take_bits(15);
        p.fetch_excp_code = r[14:0];
        return p;
    endfunction

    task automatic stop_failed();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_decoded(input string name, input decoded_t exp, input decoded_t act);
        if (act !== exp)
        begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
        begin
            $display("Fail %s expected %0d actual %0d", name, exp, act);
            stop_failed();
        end
    endtask

    // Compare process
    always @(posedge clk)
    begin
        if (!rst && out_valid && out_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("An output item appeared with no input item pending");
                stop_failed();
            end
            else
            begin
                check_decoded($sformatf("decode item %0d", recv), exp_q.pop_front(), out_dec);
                recv++;
            end
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < max_cycle)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d of %0d items received",
                 max_cycle, recv, n_items);
        stop_failed();
    end

    initial
    begin
        logic        accepted;
        logic [31:0] r;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_pkt    = '0;
        out_ready = 1'b0;
        sent      = 0;
        recv      = 0;
        accepted  = 1'b0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (sent < n_items)
        begin
            @(negedge clk);
            if (accepted)
                in_valid = 1'b0;
            accepted  = 1'b0;
            r         = take_bits(2);
            out_ready = (r != 0);
            r         = take_bits(2);
            if (!in_valid && sent < n_items && r != 0)
            begin
                in_pkt   = make_pkt();
                in_valid = 1'b1;
            end
            @(posedge clk);
            if (in_valid && in_ready)
            begin
                exp_q.push_back(decode_ref(in_pkt));
                sent++;
                accepted = 1'b1;
            end
        end
        @(negedge clk);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (4) @(negedge clk);  // At most two items still in the pipeline
        check_count("items received", sent, recv);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
common/decode_pkg.sv
source/pipe_reg.sv
decoder/alu_decoder.sv
decoder/mem_decoder.sv
decoder/branch_decoder.sv
decoder/decode_select.sv
source/decode_top.sv
tests/decode_props.sv
tests/decode_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = decode_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
